// File: hw/exu_settings.svh
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// Datapath widths
`define EXU_XLEN        32
`define EXU_PROD_W      64      // Full product, only the low half is returned

// Multiplier tree shape
`define EXU_PP_ROWS     16      // One row per radix-4 Booth digit
`define EXU_MID_ROWS    8       // Carry-save rows held at the stage register

// APB side
`define EXU_APB_AW      8

// Register map, byte offsets
`define EXU_REG_OPA     8'h00
`define EXU_REG_OPB     8'h04
`define EXU_REG_OP      8'h08
`define EXU_REG_RESULT  8'h0C
`define EXU_REG_STATUS  8'h10

`endif

// File: hw/exu_pkg.sv
`default_nettype none

package exu_pkg;

`include "exu_settings.svh"

    // Operation codes, 11 to 15 are rejected
    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_XOR = 4'd4,
        OP_SLL = 4'd5,
        OP_SRL = 4'd6,
        OP_SRA = 4'd7,
        OP_SLT = 4'd8,
        OP_EQ  = 4'd9,
        OP_MUL = 4'd10
    } alu_op_e;

    typedef struct packed {
        logic [`EXU_APB_AW-1:0] paddr;
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`EXU_XLEN-1:0]   pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`EXU_XLEN-1:0] prdata;
        logic                 pready;
        logic                 pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [`EXU_XLEN-1:0] opa;
        logic [`EXU_XLEN-1:0] opb;
        alu_op_e              op;
    } exu_issue_t;

    typedef struct packed {
        logic [`EXU_MID_ROWS-1:0][`EXU_PROD_W-1:0] row;
    } mid_rows_t;

    // Working set for one reduction level, sized for the widest level
    typedef logic [`EXU_PP_ROWS-1:0][`EXU_PROD_W-1:0] row_set_t;

    // One carry-save level: n rows in, 2*(n/3) + n%3 rows out
    function automatic row_set_t csa_level(input row_set_t rows_in, input int n);
        row_set_t rows_out;
        logic [`EXU_PROD_W-1:0] x;
        logic [`EXU_PROD_W-1:0] y;
        logic [`EXU_PROD_W-1:0] z;
        rows_out = '0;
        for (int g = 0; g < n / 3; g++) begin
            x = rows_in[3*g];
            y = rows_in[3*g+1];
            z = rows_in[3*g+2];
            rows_out[2*g]   = x ^ y ^ z;                            // Full-adder sums
            rows_out[2*g+1] = ((x & y) | (y & z) | (x & z)) << 1;   // Carries, one column up
        end
        for (int k = 0; k < n % 3; k++) begin
            rows_out[2*(n/3)+k] = rows_in[3*(n/3)+k];   // Leftover rows pass through
        end
        return rows_out;
    endfunction

endpackage

`default_nettype wire

// File: hw/int_alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "exu_settings.svh"

module int_alu (
    input  exu_pkg::exu_issue_t  issue,
    input  logic                 alu_go,
    output logic [`EXU_XLEN-1:0] alu_result
);

    logic signed [`EXU_XLEN-1:0] a;
    logic signed [`EXU_XLEN-1:0] b;
    logic [4:0]                  shamt;

    assign a     = issue.opa;
    assign b     = issue.opb;
    assign shamt = issue.opb[4:0];     // RV32 shift amount

    always_comb begin
        case (issue.op)
            exu_pkg::OP_ADD: alu_result = a + b;
            exu_pkg::OP_SUB: alu_result = a - b;
            exu_pkg::OP_AND: alu_result = a & b;
            exu_pkg::OP_OR:  alu_result = a | b;
            exu_pkg::OP_XOR: alu_result = a ^ b;
            exu_pkg::OP_SLL: alu_result = a << shamt;
            exu_pkg::OP_SRL: alu_result = issue.opa >> shamt;    // Zero fill
            exu_pkg::OP_SRA: alu_result = a >>> shamt;           // Sign fill
            exu_pkg::OP_SLT: alu_result = {{(`EXU_XLEN-1){1'b0}}, (a < b)};
            // Branch comparator, now a plain op
            exu_pkg::OP_EQ:  alu_result = {{(`EXU_XLEN-1){1'b0}}, (a == b)};
            default:         alu_result = '0;                    // MUL takes the other path
        endcase
    end

    // Multiplies are launched on mul_go only
    always_comb begin
        if (alu_go) begin
            a_no_mul_on_alu: assert final (issue.op != exu_pkg::OP_MUL)
                else $error("alu_go raised with MUL code");
        end
    end

endmodule

`default_nettype wire

// File: hw/booth_front.sv
`timescale 1ns/100ps
`default_nettype none

`include "exu_settings.svh"

module booth_front (
    input  logic                clk,
    input  logic                RST_n,
    input  exu_pkg::exu_issue_t issue,
    input  logic                mul_go,
    output exu_pkg::mid_rows_t  mid_rows,
    output logic                mid_valid
);

    localparam int PW    = `EXU_PROD_W;
    localparam int XW    = `EXU_XLEN;
    localparam int PP_N  = `EXU_PP_ROWS;
    localparam int L1_N  = 2 * (PP_N / 3) + PP_N % 3;     // 16 -> 11
    localparam int MID_N = `EXU_MID_ROWS;                 // 11 -> 8

    exu_pkg::row_set_t pp;
    exu_pkg::row_set_t l1;
    exu_pkg::row_set_t l2;

    // Digit times multiplicand, sign-extended to full product width
    function automatic logic [PW-1:0] booth_pp(input logic [2:0] dig,
                                               input logic [XW-1:0] m);
        logic [PW-1:0] mx;
        mx = {{(PW-XW){m[XW-1]}}, m};
        case (dig)
            3'b001, 3'b010: booth_pp = mx;          // +1
            3'b011:         booth_pp = mx << 1;     // +2
            3'b100:         booth_pp = -(mx << 1);  // -2
            3'b101, 3'b110: booth_pp = -mx;         // -1
            default:        booth_pp = '0;
        endcase
    endfunction

    always_comb begin
        logic [XW:0] b_ext;
        b_ext = {issue.opb, 1'b0};     // Implicit zero below bit 0
        pp    = '0;
        for (int i = 0; i < PP_N; i++) begin
            pp[i] = booth_pp(b_ext[2*i +: 3], issue.opa) << (2 * i);
        end
    end

    // Two compression levels before the stage register
    assign l1 = exu_pkg::csa_level(pp, PP_N);
    assign l2 = exu_pkg::csa_level(l1, L1_N);

    always_ff @(posedge clk) begin
        if (mul_go) mid_rows.row <= l2[MID_N-1:0];
    end

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            mid_valid <= 1'b0;
        end else begin
            mid_valid <= mul_go;
        end
    end

endmodule

`default_nettype wire

// File: hw/wallace_back.sv
`timescale 1ns/100ps
`default_nettype none

`include "exu_settings.svh"

module wallace_back (
    input  logic                 clk,
    input  logic                 RST_n,
    input  exu_pkg::mid_rows_t   mid_rows,
    input  logic                 mid_valid,
    output logic [`EXU_XLEN-1:0] prod,
    output logic                 prod_valid
);

    localparam int MID_N = `EXU_MID_ROWS;
    localparam int L3_N  = 2 * (MID_N / 3) + MID_N % 3;   // 8 -> 6
    localparam int L4_N  = 2 * (L3_N / 3) + L3_N % 3;     // 6 -> 4
    localparam int L5_N  = 2 * (L4_N / 3) + L4_N % 3;     // 4 -> 3

    exu_pkg::row_set_t    l2;
    exu_pkg::row_set_t    l3;
    exu_pkg::row_set_t    l4;
    exu_pkg::row_set_t    l5;
    exu_pkg::row_set_t    l6;
    logic [`EXU_XLEN-1:0] sum_lo;

    always_comb begin
        l2            = '0;
        l2[MID_N-1:0] = mid_rows.row;
    end

    assign l3 = exu_pkg::csa_level(l2, MID_N);
    assign l4 = exu_pkg::csa_level(l3, L3_N);
    assign l5 = exu_pkg::csa_level(l4, L4_N);
    assign l6 = exu_pkg::csa_level(l5, L5_N);     // Down to two rows

    // Upper columns never reach the low word
    assign sum_lo = l6[0][`EXU_XLEN-1:0] + l6[1][`EXU_XLEN-1:0];

    always_ff @(posedge clk) begin
        if (mid_valid) prod <= sum_lo;
    end

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= mid_valid;
        end
    end

    // One product pulse per stage-register load
    a_prod_follows_mid: assert property (@(posedge clk) disable iff (!RST_n)
        prod_valid == $past(mid_valid));

endmodule

`default_nettype wire

// File: hw/exu_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "exu_settings.svh"

module exu_ctrl (
    input  logic                 clk,
    input  logic                 RST_n,
    input  exu_pkg::apb_req_t    apb_req,
    output exu_pkg::apb_rsp_t    apb_rsp,
    output exu_pkg::exu_issue_t  issue,
    output logic                 alu_go,
    output logic                 mul_go,
    input  logic [`EXU_XLEN-1:0] alu_result,
    input  logic [`EXU_XLEN-1:0] prod,
    input  logic                 prod_valid
);

    logic [`EXU_XLEN-1:0] opa_q;
    logic [`EXU_XLEN-1:0] opb_q;
    logic [`EXU_XLEN-1:0] result_q;
    exu_pkg::alu_op_e     op_q;
    logic                 busy_q;

    logic                 access;
    logic                 wr_done;
    logic                 op_legal;
    logic                 launch;
    exu_pkg::alu_op_e     new_op;

    assign access  = apb_req.psel && apb_req.penable;
    assign wr_done = access && apb_req.pwrite && apb_rsp.pready;

    // Only 0..10 are legal, upper bits of the word must be clear
    assign op_legal = (apb_req.pwdata[`EXU_XLEN-1:4] == '0) &&
                      (apb_req.pwdata[3:0] <= exu_pkg::OP_MUL);
    assign new_op   = exu_pkg::alu_op_e'(apb_req.pwdata[3:0]);
    assign launch   = wr_done && (apb_req.paddr == `EXU_REG_OP) && op_legal;

    assign issue = '{opa: opa_q, opb: opb_q, op: op_q};

    // APB response, decoded in the access phase only
    always_comb begin
        apb_rsp = '0;
        if (access) begin
            apb_rsp.pready = 1'b1;
            case (apb_req.paddr)
                `EXU_REG_OPA: begin
                    if (!apb_req.pwrite) apb_rsp.prdata = opa_q;
                end
                `EXU_REG_OPB: begin
                    if (!apb_req.pwrite) apb_rsp.prdata = opb_q;
                end
                `EXU_REG_OP: begin
                    if (apb_req.pwrite) begin
                        apb_rsp.pready  = !busy_q;             // Held while in flight
                        apb_rsp.pslverr = !busy_q && !op_legal;
                    end else begin
                        apb_rsp.prdata = {{(`EXU_XLEN-4){1'b0}}, op_q};
                    end
                end
                `EXU_REG_RESULT: begin
                    if (apb_req.pwrite) begin
                        apb_rsp.pslverr = 1'b1;                // Read only
                    end else begin
                        apb_rsp.pready = !busy_q;
                        apb_rsp.prdata = result_q;
                    end
                end
                `EXU_REG_STATUS: begin
                    if (apb_req.pwrite) begin
                        apb_rsp.pslverr = 1'b1;
                    end else begin
                        apb_rsp.prdata = {{(`EXU_XLEN-1){1'b0}}, busy_q};
                    end
                end
                default: apb_rsp.pslverr = 1'b1;               // Unmapped, prdata stays 0
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            opa_q    <= '0;
            opb_q    <= '0;
            result_q <= '0;
            op_q     <= exu_pkg::OP_ADD;
            busy_q   <= 1'b0;
            alu_go   <= 1'b0;
            mul_go   <= 1'b0;
        end else begin
            // Strobes fire in the cycle after the OP write completes
            alu_go <= launch && (new_op != exu_pkg::OP_MUL);
            mul_go <= launch && (new_op == exu_pkg::OP_MUL);

            if (wr_done && apb_req.paddr == `EXU_REG_OPA) opa_q <= apb_req.pwdata;
            if (wr_done && apb_req.paddr == `EXU_REG_OPB) opb_q <= apb_req.pwdata;
            if (launch) op_q <= new_op;

            // ALU result is ready combinationally during the alu_go cycle
            if (alu_go) begin
                result_q <= alu_result;
            end else if (prod_valid) begin
                result_q <= prod;
            end

            if (launch) begin
                busy_q <= 1'b1;
            end else if (alu_go || prod_valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    a_pready_in_access: assert property (@(posedge clk) disable iff (!RST_n)
        apb_rsp.pready |-> (apb_req.psel && apb_req.penable));

    a_single_go: assert property (@(posedge clk) disable iff (!RST_n)
        !(alu_go && mul_go));

    // Product must belong to an operation still in flight
    a_prod_while_busy: assert property (@(posedge clk) disable iff (!RST_n)
        prod_valid |-> busy_q);

endmodule

`default_nettype wire

// File: hw/exu_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "exu_settings.svh"

module exu_top (
    input  logic              clk,
    input  logic              RST_n,
    input  exu_pkg::apb_req_t apb_req,
    output exu_pkg::apb_rsp_t apb_rsp
);

    exu_pkg::exu_issue_t  issue;
    logic                 alu_go;
    logic                 mul_go;
    logic [`EXU_XLEN-1:0] alu_result;
    exu_pkg::mid_rows_t   mid_rows;
    logic                 mid_valid;
    logic [`EXU_XLEN-1:0] prod;
    logic                 prod_valid;

    exu_ctrl ctrl0 (
        .clk        (clk),
        .RST_n      (RST_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .issue      (issue),
        .alu_go     (alu_go),
        .mul_go     (mul_go),
        .alu_result (alu_result),
        .prod       (prod),
        .prod_valid (prod_valid)
    );

    // Single-cycle path
    int_alu alu0 (
        .issue      (issue),
        .alu_go     (alu_go),
        .alu_result (alu_result)
    );

    // Two-stage multiplier
    booth_front mul_front0 (
        .clk       (clk),
        .RST_n     (RST_n),
        .issue     (issue),
        .mul_go    (mul_go),
        .mid_rows  (mid_rows),
        .mid_valid (mid_valid)
    );

    wallace_back mul_back0 (
        .clk        (clk),
        .RST_n      (RST_n),
        .mid_rows   (mid_rows),
        .mid_valid  (mid_valid),
        .prod       (prod),
        .prod_valid (prod_valid)
    );

endmodule

`default_nettype wire

// File: verification/exu_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "exu_settings.svh"

module exu_tb;

    localparam int XFER_TIMEOUT = 50;      // Cycles allowed per pready wait
    localparam int N_PAIRS      = 40;
    localparam logic [31:0] CORNERS [4] = '{32'h0000_0000, 32'h0000_0001,
                                            32'h8000_0000, 32'hFFFF_FFFF};

    logic              clk;
    logic              RST_n;
    exu_pkg::apb_req_t apb_req;
    exu_pkg::apb_rsp_t apb_rsp;

    // Each value under check is held for one clock
    logic        val_chk;
    string       val_name;
    logic [31:0] val_got;
    logic [31:0] val_exp;
    logic        err_chk;
    logic [7:0]  err_addr;
    logic        err_got;
    logic        err_exp;

    logic [31:0] rng_state;
    logic [31:0] last_result;

    exu_top dut0 (
        .clk     (clk),
        .RST_n   (RST_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    a_value: assert property (@(posedge clk) val_chk |-> (val_got == val_exp))
        else begin
            $display("ERROR %s: expected 0x%08h, actual 0x%08h", val_name, val_exp, val_got);
            $display("*** FAILED ***");
            $fatal(1, "Value mismatch");
        end

    a_pslverr: assert property (@(posedge clk) err_chk |-> (err_got == err_exp))
        else begin
            $display("ERROR pslverr at offset 0x%02h: expected 0x%h, actual 0x%h",
                     err_addr, err_exp, err_got);
            $display("*** FAILED ***");
            $fatal(1, "Error response mismatch");
        end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Expected result from the operation rules
    function automatic logic [31:0] ref_result(input exu_pkg::alu_op_e op,
                                               input logic [31:0] a, input logic [31:0] b);
        logic [63:0] wide;
        logic [4:0]  s;
        logic        lt;
        s    = b[4:0];
        lt   = (a[31] != b[31]) ? a[31] : (a < b);   // Signed compare by sign bits
        wide = {32'd0, a} * {32'd0, b};
        case (op)
            exu_pkg::OP_ADD: ref_result = a + b;
            exu_pkg::OP_SUB: ref_result = a + ~b + 32'd1;
            exu_pkg::OP_AND: ref_result = a & b;
            exu_pkg::OP_OR:  ref_result = a | b;
            exu_pkg::OP_XOR: ref_result = a ^ b;
            exu_pkg::OP_SLL: ref_result = a << s;
            exu_pkg::OP_SRL: ref_result = a >> s;
            exu_pkg::OP_SRA: ref_result = (a >> s) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> s));
            exu_pkg::OP_SLT: ref_result = {31'd0, lt};
            exu_pkg::OP_EQ:  ref_result = {31'd0, a == b};
            exu_pkg::OP_MUL: ref_result = wide[31:0];    // Low word equals the signed one
            default:         ref_result = 32'd0;
        endcase
    endfunction

    // Called and returns 2 ns after a rising edge
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output int waits);
        int   cnt;
        logic done;
        cnt             = 0;
        done            = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwrite  = wr;
        apb_req.pwdata  = wdata;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        while (!done && cnt < XFER_TIMEOUT) begin
            @(negedge clk);                            // Response is settled here
            if (apb_rsp.pready) begin
                rdata = apb_rsp.prdata;
                err   = apb_rsp.pslverr;
                done  = 1'b1;
            end else begin
                cnt++;
            end
            @(posedge clk);
            #2;
        end
        if (!done) begin
            $display("APB transfer to offset 0x%02h timed out after %0d cycles", addr, cnt);
            $display("*** FAILED ***");
            $fatal(1, "APB timeout");
        end
        waits           = cnt;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err, output int waits);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused, err, waits);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err, output int waits);
        apb_xfer(1'b0, addr, 32'd0, data, err, waits);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        val_name = name;
        val_got  = got;
        val_exp  = exp;
        val_chk  = 1'b1;
        @(posedge clk);
        #2;
        val_chk = 1'b0;
    endtask

    task automatic check_err(input logic [7:0] addr, input logic got, input logic exp);
        err_addr = addr;
        err_got  = got;
        err_exp  = exp;
        err_chk  = 1'b1;
        @(posedge clk);
        #2;
        err_chk = 1'b0;
    endtask

    task automatic check_read(input string name, input logic [7:0] addr,
                              input logic [31:0] exp_data, input logic exp_err);
        logic [31:0] data;
        logic        err;
        int          waits;
        apb_read(addr, data, err, waits);
        err_addr = addr;
        err_got  = err;
        err_exp  = exp_err;
        err_chk  = 1'b1;
        check_value(name, data, exp_data);
        err_chk = 1'b0;
    endtask

    task automatic run_op(input exu_pkg::alu_op_e op, input logic [31:0] a,
                          input logic [31:0] b);
        logic err;
        int   waits;
        apb_write(`EXU_REG_OPA, a, err, waits);
        apb_write(`EXU_REG_OPB, b, err, waits);
        apb_write(`EXU_REG_OP, {28'd0, op}, err, waits);
        last_result = ref_result(op, a, b);
        check_read($sformatf("prdata RESULT %s 0x%08h 0x%08h", op.name(), a, b),
                   `EXU_REG_RESULT, last_result, 1'b0);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] data;
        logic [31:0] status;
        logic        err;
        logic        err2;
        int          waits;
        int          rd_waits;
        RST_n       = 1'b0;
        apb_req     = '0;
        val_chk     = 1'b0;
        val_name    = "";
        val_got     = '0;
        val_exp     = '0;
        err_chk     = 1'b0;
        err_addr    = '0;
        err_got     = 1'b0;
        err_exp     = 1'b0;
        rng_state   = 32'h5278_e8dc;
        last_result = '0;
        repeat (10) @(posedge clk);
        #2;
        RST_n = 1'b1;
        @(posedge clk);
        #2;

        check_read("prdata RESULT after reset", `EXU_REG_RESULT, 32'd0, 1'b0);
        check_read("prdata STATUS after reset", `EXU_REG_STATUS, 32'd0, 1'b0);

        // ALU and EQ with equal, negative and shift-by-31 variants
        for (int i = 0; i < N_PAIRS; i++) begin
            a = lcg_next();
            b = lcg_next();
            case (i % 4)
                1: b = a;
                2: begin
                    a[31]  = 1'b1;
                    b[4:0] = 5'd31;
                end
                3: begin
                    a[31] = 1'b1;
                    b[31] = 1'b1;
                end
                default: ;
            endcase
            for (int op = 0; op <= 9; op++) run_op(exu_pkg::alu_op_e'(op), a, b);
        end

        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) run_op(exu_pkg::OP_MUL, CORNERS[i], CORNERS[j]);
        end
        for (int i = 0; i < N_PAIRS; i++) run_op(exu_pkg::OP_MUL, lcg_next(), lcg_next());

        // RESULT read right behind a MUL launch
        a = lcg_next();
        b = lcg_next();
        apb_write(`EXU_REG_OPA, a, err, waits);
        apb_write(`EXU_REG_OPB, b, err, waits);
        apb_write(`EXU_REG_OP, {28'd0, exu_pkg::OP_MUL}, err, waits);
        apb_read(`EXU_REG_RESULT, data, err, rd_waits);
        apb_read(`EXU_REG_STATUS, status, err2, waits);
        check_value("prdata RESULT held MUL", data, ref_result(exu_pkg::OP_MUL, a, b));
        check_value("pready low cycles on held RESULT read", 32'(rd_waits), 32'd2);
        check_value("prdata STATUS after held read", status, 32'd0);
        check_err(`EXU_REG_RESULT, err, 1'b0);
        check_err(`EXU_REG_STATUS, err2, 1'b0);

        // OP write while busy is held until the product is captured
        apb_write(`EXU_REG_OP, {28'd0, exu_pkg::OP_MUL}, err, waits);
        apb_write(`EXU_REG_OP, {28'd0, exu_pkg::OP_ADD}, err, waits);
        check_value("pready low cycles on held OP write", 32'(waits), 32'd2);
        check_err(`EXU_REG_OP, err, 1'b0);
        last_result = ref_result(exu_pkg::OP_ADD, a, b);
        check_read("prdata RESULT after held OP", `EXU_REG_RESULT, last_result, 1'b0);

        // Error responses leave RESULT alone
        apb_write(`EXU_REG_OP, 32'h0000_000B, err, waits);
        check_err(`EXU_REG_OP, err, 1'b1);
        apb_write(`EXU_REG_OP, 32'h0000_000F, err, waits);
        check_err(`EXU_REG_OP, err, 1'b1);
        check_read("prdata RESULT after illegal op", `EXU_REG_RESULT, last_result, 1'b0);
        check_read("prdata STATUS after illegal op", `EXU_REG_STATUS, 32'd0, 1'b0);
        apb_write(8'h14, 32'hDEAD_BEEF, err, waits);
        check_err(8'h14, err, 1'b1);
        check_read("prdata unmapped 0x20", 8'h20, 32'd0, 1'b1);
        apb_write(`EXU_REG_RESULT, 32'h1234_5678, err, waits);
        check_err(`EXU_REG_RESULT, err, 1'b1);
        apb_write(`EXU_REG_STATUS, 32'h0000_0001, err, waits);
        check_err(`EXU_REG_STATUS, err, 1'b1);
        check_read("prdata RESULT after bad accesses", `EXU_REG_RESULT, last_result, 1'b0);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hw
hw/exu_pkg.sv
hw/int_alu.sv
hw/booth_front.sv
hw/wallace_back.sv
hw/exu_ctrl.sv
hw/exu_top.sv
verification/exu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module exu_tb -f verilog.f -o exu_sim

# A failing run is judged from the log below
./obj_dir/exu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q -F '*** FAILED ***' sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
if ! grep -q -F '*** PASSED ***' sim.log; then
    echo "Simulation ended without a result, see sim.log"
    exit 1
fi
echo "Simulation passed"
